// File: hw/bus_pkg.sv
package bus_pkg;

  // default widths for the address and data buses.
  localparam int DEF_ADDR_W = 32;
  localparam int DEF_DATA_W = 32;

  // response codes on the R and B channels.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // arbiter states.
  // idle waits for a request, the others track the granted transaction.
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    IFU_RD = 2'b01,
    LSU_RD = 2'b10,
    LSU_WR = 2'b11
  } arb_state_e;

endpackage

// File: hw/mmio_pkg.sv
package mmio_pkg;

  // sram occupies MEM_WORDS words starting here.
  localparam logic [31:0] SRAM_BASE = 32'h8000_0000;

  // serial port data register.
  localparam logic [31:0] UART_ADDR = 32'ha000_03f8;

  // machine timer, low and high halves.
  localparam logic [31:0] MTIME_LO_ADDR = 32'ha000_0048;
  localparam logic [31:0] MTIME_HI_ADDR = 32'ha000_004c;

  // result of the address decode.
  typedef enum logic [1:0] {
    SEL_SRAM  = 2'b00,
    SEL_UART  = 2'b01,
    SEL_CLINT = 2'b10,
    SEL_NONE  = 2'b11
  } slave_e;

endpackage

// File: hw/axil_if.sv
`timescale 1ns/1ps

interface axil_if
  import bus_pkg::*;
#(
  parameter int ADDR_W = DEF_ADDR_W,
  parameter int DATA_W = DEF_DATA_W
) ();

  logic [ADDR_W-1:0]   araddr;
  logic                arvalid;
  logic                arready;
  logic [DATA_W-1:0]   rdata;
  resp_e               rresp;
  logic                rvalid;
  logic                rready;
  logic [ADDR_W-1:0]   awaddr;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W/8-1:0] wstrb;
  logic                awvalid;
  logic                awready;
  logic                wvalid;
  logic                wready;
  resp_e               bresp;
  logic                bvalid;
  logic                bready;

  // the arbiter side.
  modport master (
    output araddr, arvalid, rready, awaddr, wdata, wstrb, awvalid, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arvalid, rready, awaddr, wdata, wstrb, awvalid, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
  import bus_pkg::*, mmio_pkg::*;
#(
  parameter int ADDR_W    = DEF_ADDR_W,
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADDR_W-1:0]   ifu_araddr_i,
  input  logic                ifu_arvalid_i,
  output logic                ifu_arready_o,
  output logic [DATA_W-1:0]   ifu_rdata_o,
  output resp_e               ifu_rresp_o,
  output logic                ifu_rvalid_o,
  input  logic                ifu_rready_i,
  input  logic [ADDR_W-1:0]   lsu_araddr_i,
  input  logic                lsu_arvalid_i,
  output logic                lsu_arready_o,
  output logic [DATA_W-1:0]   lsu_rdata_o,
  output resp_e               lsu_rresp_o,
  output logic                lsu_rvalid_o,
  input  logic                lsu_rready_i,
  input  logic [ADDR_W-1:0]   lsu_awaddr_i,
  input  logic                lsu_awvalid_i,
  output logic                lsu_awready_o,
  input  logic [DATA_W-1:0]   lsu_wdata_i,
  input  logic [DATA_W/8-1:0] lsu_wstrb_i,
  input  logic                lsu_wvalid_i,
  output logic                lsu_wready_o,
  output resp_e               lsu_bresp_o,
  output logic                lsu_bvalid_o,
  input  logic                lsu_bready_i,
  axil_if.master              sram_bus,
  axil_if.master              uart_bus,
  axil_if.master              clint_bus
);

  localparam logic [ADDR_W-1:0] SRAM_LO   = ADDR_W'(SRAM_BASE);
  localparam logic [ADDR_W-1:0] SRAM_SPAN = ADDR_W'(MEM_WORDS * (DATA_W / 8));

  arb_state_e        state_q;
  slave_e            sel_q;
  logic              ifu_first_q;
  logic              idle;
  logic              lsu_wr_req;
  logic              lsu_any_req;
  logic              win_ifu;
  logic              win_lsu_rd;
  logic              win_lsu_wr;
  logic              rd_req;
  logic [ADDR_W-1:0] rd_addr;
  slave_e            req_sel;
  logic              rd_acc;
  logic              wr_acc;
  logic              rsp_rready;
  logic [DATA_W-1:0] rsp_rdata;
  resp_e             rsp_rresp;
  logic              rsp_rvalid;
  resp_e             rsp_bresp;
  logic              rsp_bvalid;
  logic              rsp_done;

  function automatic slave_e decode(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] ofs;
    ofs = addr - SRAM_LO;
    if (addr >= SRAM_LO && ofs < SRAM_SPAN) begin
      return SEL_SRAM;
    end else if (addr == ADDR_W'(UART_ADDR)) begin
      return SEL_UART;
    end else if (addr == ADDR_W'(MTIME_LO_ADDR) || addr == ADDR_W'(MTIME_HI_ADDR)) begin
      return SEL_CLINT;
    end
    return SEL_NONE;
  endfunction

  assign idle        = (state_q == IDLE);
  assign lsu_wr_req  = lsu_awvalid_i & lsu_wvalid_i;
  assign lsu_any_req = lsu_wr_req | lsu_arvalid_i;

  // a fetch yields to the load/store unit unless that unit had the last turn.
  assign win_ifu    = idle & ifu_arvalid_i & (ifu_first_q | ~lsu_any_req);
  assign win_lsu_wr = idle & lsu_wr_req & ~win_ifu;
  assign win_lsu_rd = idle & lsu_arvalid_i & ~lsu_wr_req & ~win_ifu;
  assign rd_req     = win_ifu | win_lsu_rd;
  assign rd_addr    = win_ifu ? ifu_araddr_i : lsu_araddr_i;
  assign req_sel    = decode(win_lsu_wr ? lsu_awaddr_i : rd_addr);

  always_comb begin
    case (req_sel)
      SEL_SRAM: begin
        rd_acc = sram_bus.arready;
        wr_acc = sram_bus.awready & sram_bus.wready;
      end
      SEL_UART: begin
        rd_acc = uart_bus.arready;
        wr_acc = uart_bus.awready & uart_bus.wready;
      end
      SEL_CLINT: begin
        rd_acc = clint_bus.arready;
        wr_acc = clint_bus.awready & clint_bus.wready;
      end
      default: begin
        // nothing lives here, so the request is taken at once.
        rd_acc = 1'b1;
        wr_acc = 1'b1;
      end
    endcase
  end

  assign ifu_arready_o = win_ifu & rd_acc;
  assign lsu_arready_o = win_lsu_rd & rd_acc;
  assign lsu_awready_o = win_lsu_wr & wr_acc;
  assign lsu_wready_o  = win_lsu_wr & wr_acc;

  assign rsp_rready = (state_q == IFU_RD) ? ifu_rready_i : ((state_q == LSU_RD) & lsu_rready_i);

  assign sram_bus.araddr  = rd_addr;
  assign sram_bus.arvalid = rd_req & (req_sel == SEL_SRAM);
  assign sram_bus.rready  = rsp_rready & (sel_q == SEL_SRAM);
  assign sram_bus.awaddr  = lsu_awaddr_i;
  assign sram_bus.wdata   = lsu_wdata_i;
  assign sram_bus.wstrb   = lsu_wstrb_i;
  assign sram_bus.awvalid = win_lsu_wr & (req_sel == SEL_SRAM);
  assign sram_bus.wvalid  = win_lsu_wr & (req_sel == SEL_SRAM);
  assign sram_bus.bready  = lsu_bready_i & (state_q == LSU_WR) & (sel_q == SEL_SRAM);

  assign uart_bus.araddr  = rd_addr;
  assign uart_bus.arvalid = rd_req & (req_sel == SEL_UART);
  assign uart_bus.rready  = rsp_rready & (sel_q == SEL_UART);
  assign uart_bus.awaddr  = lsu_awaddr_i;
  assign uart_bus.wdata   = lsu_wdata_i;
  assign uart_bus.wstrb   = lsu_wstrb_i;
  assign uart_bus.awvalid = win_lsu_wr & (req_sel == SEL_UART);
  assign uart_bus.wvalid  = win_lsu_wr & (req_sel == SEL_UART);
  assign uart_bus.bready  = lsu_bready_i & (state_q == LSU_WR) & (sel_q == SEL_UART);

  assign clint_bus.araddr  = rd_addr;
  assign clint_bus.arvalid = rd_req & (req_sel == SEL_CLINT);
  assign clint_bus.rready  = rsp_rready & (sel_q == SEL_CLINT);
  assign clint_bus.awaddr  = lsu_awaddr_i;
  assign clint_bus.wdata   = lsu_wdata_i;
  assign clint_bus.wstrb   = lsu_wstrb_i;
  assign clint_bus.awvalid = win_lsu_wr & (req_sel == SEL_CLINT);
  assign clint_bus.wvalid  = win_lsu_wr & (req_sel == SEL_CLINT);
  assign clint_bus.bready  = lsu_bready_i & (state_q == LSU_WR) & (sel_q == SEL_CLINT);

  // the unmapped case answers DECERR from the first cycle after the grant.
  always_comb begin
    rsp_rdata  = '0;
    rsp_rresp  = DECERR;
    rsp_rvalid = ~idle;
    rsp_bresp  = DECERR;
    rsp_bvalid = ~idle;
    case (sel_q)
      SEL_SRAM: begin
        rsp_rdata  = sram_bus.rdata;
        rsp_rresp  = sram_bus.rresp;
        rsp_rvalid = sram_bus.rvalid;
        rsp_bresp  = sram_bus.bresp;
        rsp_bvalid = sram_bus.bvalid;
      end
      SEL_UART: begin
        rsp_rdata  = uart_bus.rdata;
        rsp_rresp  = uart_bus.rresp;
        rsp_rvalid = uart_bus.rvalid;
        rsp_bresp  = uart_bus.bresp;
        rsp_bvalid = uart_bus.bvalid;
      end
      SEL_CLINT: begin
        rsp_rdata  = clint_bus.rdata;
        rsp_rresp  = clint_bus.rresp;
        rsp_rvalid = clint_bus.rvalid;
        rsp_bresp  = clint_bus.bresp;
        rsp_bvalid = clint_bus.bvalid;
      end
      default: begin
      end
    endcase
  end

  assign ifu_rdata_o  = rsp_rdata;
  assign ifu_rresp_o  = rsp_rresp;
  assign ifu_rvalid_o = (state_q == IFU_RD) & rsp_rvalid;
  assign lsu_rdata_o  = rsp_rdata;
  assign lsu_rresp_o  = rsp_rresp;
  assign lsu_rvalid_o = (state_q == LSU_RD) & rsp_rvalid;
  assign lsu_bresp_o  = rsp_bresp;
  assign lsu_bvalid_o = (state_q == LSU_WR) & rsp_bvalid;

  assign rsp_done = (ifu_rvalid_o & ifu_rready_i) |
                    (lsu_rvalid_o & lsu_rready_i) |
                    (lsu_bvalid_o & lsu_bready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      sel_q       <= SEL_NONE;
      ifu_first_q <= 1'b0;
    end else if (idle) begin
      // the select only matters once a grant moves the state on.
      sel_q <= req_sel;
      if (ifu_arready_o) begin
        state_q <= IFU_RD;
      end else if (lsu_arready_o) begin
        state_q <= LSU_RD;
      end else if (lsu_awready_o) begin
        state_q <= LSU_WR;
      end
    end else if (rsp_done) begin
      state_q     <= IDLE;
      ifu_first_q <= (state_q != IFU_RD);
    end
  end

endmodule

// File: hw/mem_sram.sv
`timescale 1ns/1ps

module mem_sram
  import bus_pkg::*;
#(
  parameter int ADDR_W    = DEF_ADDR_W,
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_WORDS = 256,
  parameter bit STALL_EN  = 1'b1
) (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus
);

  localparam int STRB_W = DATA_W / 8;
  localparam int OFS_W  = $clog2(STRB_W);
  localparam int IDX_W  = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [19:0]       lfsr_q;
  logic              stall;
  logic [ADDR_W-1:0] rd_word;
  logic [ADDR_W-1:0] wr_word;
  logic              rd_fire;
  logic              wr_fire;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic              bvalid_q;

  // x^20 + x^17 + 1, so the stall bit is set on about half the cycles.
  assign stall = STALL_EN & lfsr_q[19];

  assign bus.arready = ~stall & ~rvalid_q;
  assign bus.awready = ~stall & ~bvalid_q;
  assign bus.wready  = ~stall & ~bvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = OKAY;
  assign bus.rvalid  = rvalid_q;
  assign bus.bresp   = OKAY;
  assign bus.bvalid  = bvalid_q;

  assign rd_fire = bus.arvalid & bus.arready;
  assign wr_fire = bus.awvalid & bus.wvalid & bus.awready;
  assign rd_word = bus.araddr >> OFS_W;
  assign wr_word = bus.awaddr >> OFS_W;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q   <= 20'h1;
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bus.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= mem[rd_word[IDX_W-1:0]];
    end
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.wstrb[b]) begin
          mem[wr_word[IDX_W-1:0]][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
  import bus_pkg::*;
#(
  parameter int ADDR_W = DEF_ADDR_W,
  parameter int DATA_W = DEF_DATA_W
) (
  input  logic       clk,
  input  logic       rst,
  axil_if.slave      bus,
  output logic [7:0] data_o,
  output logic       valid_o
);

  logic       wr_fire;
  logic       rd_fire;
  logic [7:0] data_q;
  logic       valid_q;
  logic       bvalid_q;
  logic       rvalid_q;

  assign bus.awready = ~bvalid_q;
  assign bus.wready  = ~bvalid_q;
  assign bus.bresp   = OKAY;
  assign bus.bvalid  = bvalid_q;
  assign bus.arready = ~rvalid_q;
  assign bus.rdata   = '0;
  assign bus.rresp   = SLVERR;
  assign bus.rvalid  = rvalid_q;

  assign wr_fire = bus.awvalid & bus.wvalid & bus.awready;
  assign rd_fire = bus.arvalid & bus.arready;
  assign data_o  = data_q;
  assign valid_o = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      valid_q <= wr_fire;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bus.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      data_q <= bus.wdata[7:0];
    end
  end

endmodule

// File: hw/clint_timer.sv
`timescale 1ns/1ps

module clint_timer
  import bus_pkg::*;
#(
  parameter int ADDR_W = DEF_ADDR_W,
  parameter int DATA_W = DEF_DATA_W
) (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus
);

  logic [63:0]       mtime_q;
  logic [ADDR_W-1:0] word_ofs;
  logic              rd_fire;
  logic              wr_fire;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic              bvalid_q;

  // nonzero for the high half, which sits one word above the low half.
  assign word_ofs = bus.araddr & ADDR_W'(DATA_W / 8);

  assign bus.arready = ~rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = OKAY;
  assign bus.rvalid  = rvalid_q;
  assign bus.awready = ~bvalid_q;
  assign bus.wready  = ~bvalid_q;
  assign bus.bresp   = SLVERR;
  assign bus.bvalid  = bvalid_q;

  assign rd_fire = bus.arvalid & bus.arready;
  assign wr_fire = bus.awvalid & bus.wvalid & bus.awready;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q  <= '0;
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bus.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= (|word_ofs) ? DATA_W'(mtime_q[63:32]) : DATA_W'(mtime_q[31:0]);
    end
  end

endmodule

// File: hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
  import bus_pkg::*;
#(
  parameter int ADDR_W    = DEF_ADDR_W,
  parameter int DATA_W    = DEF_DATA_W,
  parameter int MEM_WORDS = 256,
  parameter bit STALL_EN  = 1'b1
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADDR_W-1:0]   ifu_araddr_i,
  input  logic                ifu_arvalid_i,
  output logic                ifu_arready_o,
  output logic [DATA_W-1:0]   ifu_rdata_o,
  output resp_e               ifu_rresp_o,
  output logic                ifu_rvalid_o,
  input  logic                ifu_rready_i,
  input  logic [ADDR_W-1:0]   lsu_araddr_i,
  input  logic                lsu_arvalid_i,
  output logic                lsu_arready_o,
  output logic [DATA_W-1:0]   lsu_rdata_o,
  output resp_e               lsu_rresp_o,
  output logic                lsu_rvalid_o,
  input  logic                lsu_rready_i,
  input  logic [ADDR_W-1:0]   lsu_awaddr_i,
  input  logic                lsu_awvalid_i,
  output logic                lsu_awready_o,
  input  logic [DATA_W-1:0]   lsu_wdata_i,
  input  logic [DATA_W/8-1:0] lsu_wstrb_i,
  input  logic                lsu_wvalid_i,
  output logic                lsu_wready_o,
  output resp_e               lsu_bresp_o,
  output logic                lsu_bvalid_o,
  input  logic                lsu_bready_i,
  output logic [7:0]          uart_data_o,
  output logic                uart_valid_o
);

  axil_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) sram_bus ();
  axil_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uart_bus ();
  axil_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) clint_bus ();

  // master ports and slave interfaces share their names with the arbiter ports.
  bus_arbiter #(
    .ADDR_W   (ADDR_W),
    .DATA_W   (DATA_W),
    .MEM_WORDS(MEM_WORDS)
  ) u_arbiter (.*);

  mem_sram #(
    .ADDR_W   (ADDR_W),
    .DATA_W   (DATA_W),
    .MEM_WORDS(MEM_WORDS),
    .STALL_EN (STALL_EN)
  ) u_sram (
    .clk(clk),
    .rst(rst),
    .bus(sram_bus)
  );

  uart_tx #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_uart (
    .clk    (clk),
    .rst    (rst),
    .bus    (uart_bus),
    .data_o (uart_data_o),
    .valid_o(uart_valid_o)
  );

  clint_timer #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_clint (
    .clk(clk),
    .rst(rst),
    .bus(clint_bus)
  );

endmodule

// File: test/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus
  import bus_pkg::*, mmio_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int MEM_WORDS  = 256;
  localparam int NUM_TXN    = 300;
  // sram init writes and the directed accesses come on top of both random streams.
  localparam int TXN_BUDGET = MEM_WORDS + 2 * NUM_TXN + 16;
  localparam int TIMEOUT_NS = TXN_BUDGET * 40 * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h60db2446;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] ifu_araddr_i;
  logic        ifu_arvalid_i;
  logic        ifu_arready_o;
  logic [31:0] ifu_rdata_o;
  resp_e       ifu_rresp_o;
  logic        ifu_rvalid_o;
  logic        ifu_rready_i;
  logic [31:0] lsu_araddr_i;
  logic        lsu_arvalid_i;
  logic        lsu_arready_o;
  logic [31:0] lsu_rdata_o;
  resp_e       lsu_rresp_o;
  logic        lsu_rvalid_o;
  logic        lsu_rready_i;
  logic [31:0] lsu_awaddr_i;
  logic        lsu_awvalid_i;
  logic        lsu_awready_o;
  logic [31:0] lsu_wdata_i;
  logic [3:0]  lsu_wstrb_i;
  logic        lsu_wvalid_i;
  logic        lsu_wready_o;
  resp_e       lsu_bresp_o;
  logic        lsu_bvalid_o;
  logic        lsu_bready_i;
  logic [7:0]  uart_data_o;
  logic        uart_valid_o;

  logic [31:0] model_mem [MEM_WORDS];
  logic [7:0]  uart_expect [$];
  logic [31:0] ifu_lfsr;
  logic [31:0] lsu_lfsr;
  int          checks;
  int          errors;
  int          done_count;
  int unsigned cycle = 0;

  soc_bus_top #(
    .MEM_WORDS(MEM_WORDS),
    .STALL_EN (1'b1)
  ) DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit returned.
  function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = data[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic logic [31:0] sram_addr(input logic [7:0] idx);
    return SRAM_BASE + {22'h0, idx, 2'b00};
  endfunction

  // either below the sram base or just past its last word.
  function automatic logic [31:0] unmapped_addr(input logic [31:0] r);
    if (r[31]) begin
      return {1'b0, r[30:2], 2'b00};
    end
    return SRAM_BASE + 32'(MEM_WORDS * 4) + {18'h0, r[13:2], 2'b00};
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic match_resp(input string what, input resp_e got, input resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s answered %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic verify_held(input string who, input logic valid, input logic [31:0] data,
                             input logic [31:0] data_h, input resp_e resp, input resp_e resp_h);
    checks++;
    if (!valid || data !== data_h || resp !== resp_h) begin
      errors++;
      $display("FAIL %0t: %s response dropped or changed while ready was low", $time, who);
    end
  endtask

  task automatic bound_wait(input string who, input int start);
    checks++;
    if (done_count - start > 2) begin
      errors++;
      $display("%0t: %s waited for %0d other transactions before its grant",
               $time, who, done_count - start);
    end
  endtask

  // each bus task starts and ends 2 ns after a rising edge.
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data,
                            output resp_e resp);
    int          start;
    logic        accepted;
    logic        held;
    logic        done;
    logic [31:0] data_h;
    resp_e       resp_h;
    start = done_count;
    accepted = 1'b0;
    held = 1'b0;
    done = 1'b0;
    data_h = '0;
    resp_h = OKAY;
    ifu_araddr_i = addr;
    ifu_arvalid_i = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      accepted = ifu_arready_o;
      @(posedge clk);
      #2;
    end
    ifu_arvalid_i = 1'b0;
    bound_wait("fetch", start);
    while (!done) begin
      ifu_rready_i = 1'(rand_bits(ifu_lfsr, 1));
      @(negedge clk);
      if (held) begin
        verify_held("fetch read", ifu_rvalid_o, ifu_rdata_o, data_h, ifu_rresp_o, resp_h);
      end
      if (ifu_rvalid_o && ifu_rready_i) begin
        done = 1'b1;
        data = ifu_rdata_o;
        resp = ifu_rresp_o;
        done_count++;
      end else if (ifu_rvalid_o) begin
        held = 1'b1;
        data_h = ifu_rdata_o;
        resp_h = ifu_rresp_o;
      end
      @(posedge clk);
      #2;
    end
    ifu_rready_i = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr, input logic bp, output logic [31:0] data,
                           output resp_e resp, output int unsigned at_cycle);
    int          start;
    logic        accepted;
    logic        held;
    logic        done;
    logic [31:0] data_h;
    resp_e       resp_h;
    start = done_count;
    accepted = 1'b0;
    held = 1'b0;
    done = 1'b0;
    data_h = '0;
    resp_h = OKAY;
    lsu_araddr_i = addr;
    lsu_arvalid_i = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      accepted = lsu_arready_o;
      @(posedge clk);
      #2;
    end
    lsu_arvalid_i = 1'b0;
    bound_wait("load", start);
    while (!done) begin
      lsu_rready_i = bp ? 1'(rand_bits(lsu_lfsr, 1)) : 1'b1;
      @(negedge clk);
      if (held) begin
        verify_held("load read", lsu_rvalid_o, lsu_rdata_o, data_h, lsu_rresp_o, resp_h);
      end
      if (lsu_rvalid_o && lsu_rready_i) begin
        done = 1'b1;
        data = lsu_rdata_o;
        resp = lsu_rresp_o;
        at_cycle = cycle;
        done_count++;
      end else if (lsu_rvalid_o) begin
        held = 1'b1;
        data_h = lsu_rdata_o;
        resp_h = lsu_rresp_o;
      end
      @(posedge clk);
      #2;
    end
    lsu_rready_i = 1'b0;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output resp_e resp);
    int    start;
    logic  accepted;
    logic  held;
    logic  done;
    resp_e resp_h;
    start = done_count;
    accepted = 1'b0;
    held = 1'b0;
    done = 1'b0;
    resp_h = OKAY;
    lsu_awaddr_i = addr;
    lsu_wdata_i = data;
    lsu_wstrb_i = strb;
    lsu_awvalid_i = 1'b1;
    lsu_wvalid_i = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      if (lsu_awready_o !== lsu_wready_o) begin
        errors++;
        $display("%0t: write address and write data were not accepted together", $time);
      end
      accepted = lsu_awready_o & lsu_wready_o;
      // the serial strobe follows one cycle after the accept.
      if (accepted && addr == UART_ADDR) begin
        uart_expect.push_back(data[7:0]);
      end
      @(posedge clk);
      #2;
    end
    lsu_awvalid_i = 1'b0;
    lsu_wvalid_i = 1'b0;
    bound_wait("store", start);
    while (!done) begin
      lsu_bready_i = 1'(rand_bits(lsu_lfsr, 1));
      @(negedge clk);
      if (held) begin
        verify_held("store", lsu_bvalid_o, 32'h0, 32'h0, lsu_bresp_o, resp_h);
      end
      if (lsu_bvalid_o && lsu_bready_i) begin
        done = 1'b1;
        resp = lsu_bresp_o;
        done_count++;
      end else if (lsu_bvalid_o) begin
        held = 1'b1;
        resp_h = lsu_bresp_o;
      end
      @(posedge clk);
      #2;
    end
    lsu_bready_i = 1'b0;
  endtask

  task automatic uart_watch();
    logic [7:0] exp_byte;
    forever begin
      @(negedge clk);
      if (uart_valid_o) begin
        if (uart_expect.size() == 0) begin
          errors++;
          $display("%0t: serial strobe with no write waiting for it", $time);
        end else begin
          exp_byte = uart_expect.pop_front();
          compare_word("serial byte", {24'h0, uart_data_o}, {24'h0, exp_byte});
        end
      end
    end
  endtask

  task automatic directed_setup();
    logic [31:0] data;
    logic [31:0] t1;
    logic [31:0] t2;
    resp_e       resp;
    int unsigned c1;
    int unsigned c2;
    for (int i = 0; i < MEM_WORDS; i++) begin
      data = rand_bits(lsu_lfsr, 32);
      store_word(sram_addr(8'(i)), data, 4'hf, resp);
      match_resp("sram init write", resp, OKAY);
      model_mem[i] = data;
    end
    load_word(MTIME_HI_ADDR, 1'b0, data, resp, c1);
    match_resp("mtime high read", resp, OKAY);
    compare_word("mtime high read", data, 32'h0);
    load_word(MTIME_LO_ADDR, 1'b0, t1, resp, c1);
    match_resp("mtime low read", resp, OKAY);
    load_word(MTIME_LO_ADDR, 1'b0, t2, resp, c2);
    match_resp("mtime low read", resp, OKAY);
    checks++;
    if (t2 <= t1 || t2 - t1 > c2 - c1) begin
      errors++;
      $display("FAIL %0t: mtime went from %0d to %0d over %0d cycles", $time, t1, t2, c2 - c1);
    end
    store_word(MTIME_LO_ADDR, rand_bits(lsu_lfsr, 32), 4'hf, resp);
    match_resp("mtime write", resp, SLVERR);
    load_word(UART_ADDR, 1'b1, data, resp, c1);
    match_resp("serial port read", resp, SLVERR);
  endtask

  task automatic ifu_traffic();
    logic [2:0]  kind;
    logic [7:0]  idx;
    logic [31:0] data;
    resp_e       resp;
    for (int n = 0; n < NUM_TXN; n++) begin
      kind = 3'(rand_bits(ifu_lfsr, 3));
      idx = 8'(rand_bits(ifu_lfsr, 8));
      if (kind == 3'd7) begin
        fetch_word(unmapped_addr(rand_bits(ifu_lfsr, 32)), data, resp);
        match_resp("fetch from unmapped address", resp, DECERR);
      end else begin
        fetch_word(sram_addr(idx), data, resp);
        match_resp("fetch from sram", resp, OKAY);
        compare_word("fetch from sram", data, model_mem[idx]);
      end
      repeat (rand_bits(ifu_lfsr, 2)) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic lsu_traffic();
    logic [3:0]  kind;
    logic [7:0]  idx;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] addr;
    logic [31:0] rdata;
    resp_e       resp;
    int unsigned c;
    for (int n = 0; n < NUM_TXN; n++) begin
      kind = 4'(rand_bits(lsu_lfsr, 4));
      idx = 8'(rand_bits(lsu_lfsr, 8));
      data = rand_bits(lsu_lfsr, 32);
      strb = 4'(rand_bits(lsu_lfsr, 4));
      if (kind <= 4'd5) begin
        store_word(sram_addr(idx), data, strb, resp);
        match_resp("store to sram", resp, OKAY);
        model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
      end else if (kind <= 4'd10) begin
        load_word(sram_addr(idx), 1'b1, rdata, resp, c);
        match_resp("load from sram", resp, OKAY);
        compare_word("load from sram", rdata, model_mem[idx]);
      end else if (kind == 4'd11) begin
        store_word(UART_ADDR, data, strb, resp);
        match_resp("serial port write", resp, OKAY);
      end else if (kind == 4'd12) begin
        load_word(UART_ADDR, 1'b1, rdata, resp, c);
        match_resp("serial port read", resp, SLVERR);
      end else if (kind == 4'd13) begin
        addr = unmapped_addr(rand_bits(lsu_lfsr, 32));
        store_word(addr, data, strb, resp);
        match_resp("store to unmapped address", resp, DECERR);
        // the word with the same low address bits must be untouched.
        load_word(sram_addr(addr[9:2]), 1'b1, rdata, resp, c);
        match_resp("load after unmapped store", resp, OKAY);
        compare_word("load after unmapped store", rdata, model_mem[addr[9:2]]);
      end else if (kind == 4'd14) begin
        load_word(unmapped_addr(rand_bits(lsu_lfsr, 32)), 1'b1, rdata, resp, c);
        match_resp("load from unmapped address", resp, DECERR);
      end else begin
        store_word(data[0] ? MTIME_HI_ADDR : MTIME_LO_ADDR, data, strb, resp);
        match_resp("mtime write", resp, SLVERR);
      end
      repeat (rand_bits(lsu_lfsr, 2)) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 1'b0;
    ifu_rready_i = 1'b0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rready_i = 1'b0;
    lsu_awaddr_i = '0;
    lsu_awvalid_i = 1'b0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_wvalid_i = 1'b0;
    lsu_bready_i = 1'b0;
    checks = 0;
    errors = 0;
    done_count = 0;
    lsu_lfsr = SEED;
    ifu_lfsr = rand_bits(lsu_lfsr, 32);
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    fork
      uart_watch();
    join_none
    directed_setup();
    fork
      ifu_traffic();
      lsu_traffic();
    join
    repeat (4) @(posedge clk);
    checks++;
    if (uart_expect.size() != 0) begin
      errors++;
      $display("%0t: %0d serial bytes were written but never strobed", $time, uart_expect.size());
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the bus transactions did not finish within %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: project.f
hw/bus_pkg.sv
hw/mmio_pkg.sv
hw/axil_if.sv
hw/bus_arbiter.sv
hw/mem_sram.sv
hw/uart_tx.sv
hw/clint_timer.sv
hw/soc_bus_top.sv
test/tb_soc_bus.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_soc_bus -f project.f --Mdir obj_dir -o tb_soc_bus
	./obj_dir/tb_soc_bus | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
